//--- verilog/sig_md_pkg.sv
`default_nettype none

package sig_md_pkg;

    // Operand and result widths of the significand unit.
    localparam int sig_w = 53;
    localparam int op_w = 58;
    localparam int prod_w = 2 * op_w;
    localparam int res_w = 57;

    // The reciprocal table has 2**seed_w entries of seed_w bits.
    localparam int seed_w = 8;

    // Quotient bits below the single precision grid.
    localparam int single_mask_w = 29;

    // Newton-Raphson iteration counts.
    localparam int iter_dp = 3;
    localparam int iter_sp = 2;

    // Cycles from the start pulse to done.
    localparam int mul_latency = 2;
    localparam int div_latency_dp = 2 * iter_dp + 5;
    localparam int div_latency_sp = 2 * iter_sp + 5;

    typedef enum logic [2:0] {
        sel_plain,
        sel_seed,
        sel_refine,
        sel_scale,
        sel_quot,
        sel_back
    } op_sel_t;

endpackage

`default_nettype wire

//--- verilog/recip_rom.sv
`default_nettype none

module recip_rom (
    input  wire                           clk,
    input  wire [sig_md_pkg::seed_w-1:0]  addr,
    output logic [sig_md_pkg::seed_w-1:0] seed
);

    import sig_md_pkg::*;

    localparam int depth = 2 ** seed_w;

    typedef logic [seed_w-1:0] table_t [depth];

    // Entry i is the reciprocal of the midpoint of [1.i, 1.i + 1/256),
    // i.e. 2**(w+1)/(2**(w+1) + 1 + 2i), rounded to 2**-(w+1).
    // The result lies in (0.5, 1], so only the bits below 0.5 are kept.
    function automatic table_t build_table();
        table_t      t;
        int unsigned den;
        int unsigned num;
        int unsigned r;
        num = 2 ** (2 * seed_w + 2);
        for (int i = 0; i < depth; i++) begin
            den = 2 ** (seed_w + 1) + 1 + 2 * i;
            // Round to nearest.
            r = (2 * num + den) / (2 * den);
            t[i] = seed_w'(r - 2 ** seed_w);
        end
        return t;
    endfunction

    localparam table_t recip_table = build_table();

    always_ff @(posedge clk) begin
        seed <= recip_table[addr];
    end

endmodule

`default_nettype wire

//--- verilog/nr_datapath.sv
`default_nettype none

module nr_datapath (
    input  wire                            clk,
    input  wire                            reset,
    input  wire [sig_md_pkg::sig_w-1:0]    fa,
    input  wire [sig_md_pkg::sig_w-1:0]    fb,
    input  wire                            db,
    input  wire [sig_md_pkg::seed_w-1:0]   seed,
    input  wire sig_md_pkg::op_sel_t       op_sel,
    input  wire                            mul_en,
    input  wire                            recip_load,
    input  wire                            corr_load,
    output logic [sig_md_pkg::prod_w-1:0]  product,
    output logic [sig_md_pkg::res_w-2:0]   q_est
);

    import sig_md_pkg::*;

    localparam int q_w = res_w - 1;

    // All multiplier operands carry 57 fractional bits, so the product
    // has 114. Only the plain multiply can set its top bit.
    logic [op_w-1:0] fa_op;
    logic [op_w-1:0] fb_op;
    logic [op_w-1:0] seed_op;
    logic [op_w-1:0] p_top;
    logic [op_w-1:0] lo_mask;
    logic [op_w-1:0] recip_q;
    logic [op_w-1:0] recip_d;
    logic [op_w-1:0] recip_cur;
    logic [op_w-1:0] a_op;
    logic [op_w-1:0] b_op;
    logic [q_w-1:0]  q_mask;
    logic [q_w-1:0]  q_d;
    logic [q_w-1:0]  q_cur;

    assign fa_op = {fa, {(op_w - sig_w){1'b0}}};
    assign fb_op = {fb, {(op_w - sig_w){1'b0}}};

    // Seed value is 0.1 followed by the table entry.
    assign seed_op = {2'b01, seed, {(op_w - seed_w - 2){1'b0}}};

    assign p_top = product[prod_w-2 -: op_w];

    // Single precision keeps the reciprocal and the quotient on a coarse grid.
    assign lo_mask = db ? {op_w{1'b1}} : {{(op_w - single_mask_w){1'b1}},
                                          {single_mask_w{1'b0}}};
    assign q_mask = db ? {q_w{1'b1}} : {{(q_w - single_mask_w){1'b1}},
                                        {single_mask_w{1'b0}}};

    assign recip_d = ((op_sel == sel_seed) ? seed_op : p_top) & lo_mask;
    assign q_d = product[prod_w-2 -: q_w] & q_mask;

    // A value being loaded this cycle is forwarded to the multiplier.
    assign recip_cur = recip_load ? recip_d : recip_q;
    assign q_cur = corr_load ? q_d : q_est;

    always_comb begin
        case (op_sel)
            sel_seed: begin
                a_op = seed_op;
                b_op = fb_op;
            end
            sel_refine: begin
                // Two minus the scaled product, in two's complement.
                a_op = recip_q;
                b_op = -p_top;
            end
            sel_scale: begin
                a_op = recip_cur;
                b_op = fb_op;
            end
            sel_quot: begin
                a_op = fa_op;
                b_op = recip_q;
            end
            sel_back: begin
                a_op = {q_cur, {(op_w - q_w){1'b0}}};
                b_op = fb_op;
            end
            default: begin
                a_op = fa_op;
                b_op = fb_op;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            product <= '0;
            recip_q <= '0;
            q_est <= '0;
        end else begin
            if (mul_en) begin
                product <= a_op * b_op;
            end
            if (recip_load) begin
                recip_q <= recip_d;
            end
            if (corr_load) begin
                q_est <= q_d;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/quot_select.sv
`default_nettype none

module quot_select (
    input  wire                            clk,
    input  wire                            reset,
    input  wire [sig_md_pkg::sig_w-1:0]    fa,
    input  wire [sig_md_pkg::sig_w-1:0]    fb,
    input  wire                            db,
    input  wire [sig_md_pkg::prod_w-1:0]   product,
    input  wire [sig_md_pkg::res_w-2:0]    q_est,
    input  wire                            res_load,
    input  wire                            res_div,
    output logic [sig_md_pkg::res_w-1:0]   fq
);

    import sig_md_pkg::*;

    localparam int q_w = res_w - 1;
    // Remainder width, with room for the sign.
    localparam int rw = sig_w + q_w + 2;
    // The back product q*fb sits this many bits up in the product register.
    localparam int bp_lsb = 2 * op_w - q_w - sig_w;

    logic [rw-1:0]    dividend;
    logic [rw-1:0]    back_prod;
    logic [rw-1:0]    step;
    logic [rw-1:0]    rem;
    logic [rw-1:0]    rem_fix;
    logic [q_w-1:0]   q_unit;
    logic [q_w-1:0]   q_fix;
    logic             sticky;
    logic [res_w-1:0] div_res;
    logic [res_w-1:0] mul_res;
    logic [res_w-1:0] fq_next;
    logic [res_w-1:0] fq_q;

    // The remainder is fa*2**55 - q*fb, in units of the last quotient bit.
    assign dividend = rw'({fa, {(q_w - 1){1'b0}}});
    assign back_prod = rw'(product[prod_w-1:bp_lsb]);
    assign rem = dividend - back_prod;

    assign q_unit = db ? q_w'(1) : (q_w'(1) << single_mask_w);
    assign step = db ? rw'(fb) : (rw'(fb) << single_mask_w);

    // The estimate is at most one unit away from the truncated quotient.
    always_comb begin
        q_fix = q_est;
        rem_fix = rem;
        if (rem[rw-1]) begin
            q_fix = q_est - q_unit;
            rem_fix = rem + step;
        end else if (rem >= step) begin
            q_fix = q_est + q_unit;
            rem_fix = rem - step;
        end
    end

    assign sticky = |rem_fix;

    assign div_res = db ? {q_fix, sticky}
                        : {q_fix[q_w-1:single_mask_w], sticky, {single_mask_w{1'b0}}};

    assign mul_res = {product[prod_w-1 -: q_w], |product[prod_w-q_w-1:0]};

    assign fq_next = res_div ? div_res : mul_res;

    always_ff @(posedge clk) begin
        if (reset) begin
            fq_q <= '0;
        end else if (res_load) begin
            fq_q <= fq_next;
        end
    end

    // The new result is forwarded in the done cycle and held afterwards.
    assign fq = res_load ? fq_next : fq_q;

endmodule

`default_nettype wire

//--- verilog/sig_md_ctrl.sv
`default_nettype none

module sig_md_ctrl (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  start,
    input  wire                  fdiv,
    input  wire                  db,
    output logic                 busy,
    output logic                 done,
    output sig_md_pkg::op_sel_t  op_sel,
    output logic                 mul_en,
    output logic                 recip_load,
    output logic                 corr_load,
    output logic                 res_load,
    output logic                 res_div
);

    import sig_md_pkg::*;

    localparam int cnt_w = $clog2(iter_dp + 1);

    typedef enum logic [3:0] {
        st_idle,
        st_mul,
        st_rom,
        st_seed,
        st_refine,
        st_scale,
        st_quot,
        st_back,
        st_finish
    } state_t;

    state_t           state;
    state_t           state_nxt;
    logic [cnt_w-1:0] iter_cnt;
    logic             is_div;

    // The seed multiply is the first scale step, so every refine is followed
    // by a scale that moves the new reciprocal into its register.
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (start) begin
                    state_nxt = fdiv ? st_rom : st_mul;
                end
            end
            st_mul:    state_nxt = st_finish;
            st_rom:    state_nxt = st_seed;
            st_seed:   state_nxt = st_refine;
            st_refine: state_nxt = st_scale;
            st_scale:  state_nxt = (iter_cnt == '0) ? st_quot : st_refine;
            st_quot:   state_nxt = st_back;
            st_back:   state_nxt = st_finish;
            default:   state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            iter_cnt <= '0;
            is_div <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == st_idle && start) begin
                iter_cnt <= db ? cnt_w'(iter_dp) : cnt_w'(iter_sp);
                is_div <= fdiv;
            end else if (state == st_refine) begin
                iter_cnt <= iter_cnt - 1'b1;
            end
        end
    end

    always_comb begin
        case (state)
            st_seed:   op_sel = sel_seed;
            st_refine: op_sel = sel_refine;
            st_scale:  op_sel = sel_scale;
            st_quot:   op_sel = sel_quot;
            st_back:   op_sel = sel_back;
            default:   op_sel = sel_plain;
        endcase
    end

    assign busy = (state != st_idle);
    assign done = (state == st_finish);
    assign res_load = (state == st_finish);
    assign res_div = is_div;
    assign mul_en = (state != st_idle) && (state != st_rom) && (state != st_finish);
    assign recip_load = (state == st_seed) || (state == st_scale);
    assign corr_load = (state == st_back);

endmodule

`default_nettype wire

//--- verilog/sig_md_top.sv
`default_nettype none

module sig_md_top (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           start,
    input  wire [sig_md_pkg::sig_w-1:0]   fa,
    input  wire [sig_md_pkg::sig_w-1:0]   fb,
    input  wire                           fdiv,
    input  wire                           db,
    output wire                           busy,
    output wire                           done,
    output wire [sig_md_pkg::res_w-1:0]   fq
);

    import sig_md_pkg::*;

    op_sel_t           op_sel;
    logic              mul_en;
    logic              recip_load;
    logic              corr_load;
    logic              res_load;
    logic              res_div;
    logic [seed_w-1:0] seed;
    logic [prod_w-1:0] product;
    logic [res_w-2:0]  q_est;

    sig_md_ctrl i_ctrl (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .fdiv       (fdiv),
        .db         (db),
        .busy       (busy),
        .done       (done),
        .op_sel     (op_sel),
        .mul_en     (mul_en),
        .recip_load (recip_load),
        .corr_load  (corr_load),
        .res_load   (res_load),
        .res_div    (res_div)
    );

    // Table index is the fraction of fb just below the hidden bit.
    recip_rom i_rom (
        .clk  (clk),
        .addr (fb[sig_w-2 -: seed_w]),
        .seed (seed)
    );

    nr_datapath i_datapath (
        .clk        (clk),
        .reset      (reset),
        .fa         (fa),
        .fb         (fb),
        .db         (db),
        .seed       (seed),
        .op_sel     (op_sel),
        .mul_en     (mul_en),
        .recip_load (recip_load),
        .corr_load  (corr_load),
        .product    (product),
        .q_est      (q_est)
    );

    quot_select i_select (
        .clk      (clk),
        .reset    (reset),
        .fa       (fa),
        .fb       (fb),
        .db       (db),
        .product  (product),
        .q_est    (q_est),
        .res_load (res_load),
        .res_div  (res_div),
        .fq       (fq)
    );

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int period = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(period / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- verification/sig_md_tb.sv
`default_nettype none

module sig_md_tb;

    import sig_md_pkg::*;

    localparam int drive_delay = 1;
    localparam int sp_frac = sig_w - 1 - single_mask_w;
    localparam int n_mul = 200;
    localparam int n_dp = 200;
    localparam int n_sp = 200;
    localparam int n_busy = 12;
    localparam int n_mix = 120;
    // Every operation, including the idle cycle after it, fits in this many cycles.
    localparam int watchdog_cycles =
        (n_mul + n_dp + n_sp + n_busy + n_mix) * (div_latency_dp + 4) + 64;

    logic             clk;
    logic             reset;
    logic             start;
    logic [sig_w-1:0] fa;
    logic [sig_w-1:0] fb;
    logic             fdiv;
    logic             db;
    logic             busy;
    logic             done;
    logic [res_w-1:0] fq;
    logic [res_w-1:0] last_fq = '0;
    logic [15:0]      lfsr = 16'd20616;
    int               errors = 0;
    int               checks = 0;
    int               tests = 0;

    tb_clock_gen #(.period(4)) i_clock_gen (.clk(clk));

    sig_md_top i_sig_md_top (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .fa    (fa),
        .fb    (fb),
        .fdiv  (fdiv),
        .db    (db),
        .busy  (busy),
        .done  (done),
        .fq    (fq)
    );

    // Taps 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[62:0], lfsr[0]};
        end
    endtask

    task automatic random_sig(input logic single, output logic [sig_w-1:0] s);
        logic [63:0] bits;
        if (single) begin
            draw_bits(sp_frac, bits);
            s = {1'b1, bits[sp_frac-1:0], {single_mask_w{1'b0}}};
        end else begin
            draw_bits(sig_w - 1, bits);
            s = {1'b1, bits[sig_w-2:0]};
        end
    endtask

    function automatic logic [res_w-1:0] mul_model(input logic [sig_w-1:0] a,
                                                    input logic [sig_w-1:0] b);
        logic [115:0] p;
        p = 116'({a, 5'b0}) * 116'({b, 5'b0});
        return {p[115:60], |p[59:0]};
    endfunction

    // Quotient of a*2**shift/b, truncated, with a sticky bit for the remainder.
    function automatic logic [res_w-1:0] div_model(input logic [sig_w-1:0] a,
                                                    input logic [sig_w-1:0] b,
                                                    input logic dbl);
        logic [127:0] num;
        logic [127:0] q;
        logic [127:0] r;
        num = dbl ? (128'(a) << 55) : (128'(a) << 26);
        q = num / 128'(b);
        r = num % 128'(b);
        if (dbl) begin
            return {q[55:0], r != 0};
        end
        return {q[26:0], r != 0, {single_mask_w{1'b0}}};
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
        errors++;
        $display("error at %0t: %s got %0h, expected %0h", $time, name, got, exp);
    endtask

    // Starts one operation in the current cycle and follows it to the cycle after done.
    // A nonzero spur gives an extra start pulse in that cycle of the operation.
    task automatic run_op(input logic [sig_w-1:0] a, input logic [sig_w-1:0] b,
                          input logic div, input logic dbl, input int spur);
        logic [res_w-1:0] exp_fq;
        int               exp_lat;
        int               cycles;
        bit               seen;
        exp_fq = div ? div_model(a, b, dbl) : mul_model(a, b);
        exp_lat = div ? (dbl ? div_latency_dp : div_latency_sp) : mul_latency;
        fa = a;
        fb = b;
        fdiv = div;
        db = dbl;
        start = 1'b1;
        cycles = 0;
        seen = 0;
        while (!seen && cycles <= exp_lat + 4) begin
            @(posedge clk);
            #drive_delay;
            cycles++;
            start = (cycles == spur);
            @(negedge clk);
            checks += 2;
            if (busy !== 1'b1) report_mismatch("busy", busy, 1);
            if (done === 1'b1) begin
                seen = 1;
            end else if (fq !== last_fq) begin
                // The previous result stays on fq until the next done.
                report_mismatch("fq before done", fq, last_fq);
            end
        end
        if (!seen) begin
            errors++;
            $display("operation at %0t never raised done", $time);
        end else begin
            checks += 2;
            if (cycles != exp_lat) report_mismatch("done cycle", cycles, exp_lat);
            if (fq !== exp_fq) report_mismatch("fq", fq, exp_fq);
        end
        @(posedge clk);
        #drive_delay;
        start = 1'b0;
        checks += 3;
        if (busy !== 1'b0) report_mismatch("busy after done", busy, 0);
        if (done !== 1'b0) report_mismatch("done after done", done, 0);
        if (fq !== exp_fq) report_mismatch("fq held", fq, exp_fq);
        last_fq = exp_fq;
    endtask

    // Kind 0 is a multiply, 1 a double divide and 2 a single divide.
    task automatic run_random(input int kind, input int spur);
        logic [sig_w-1:0] a;
        logic [sig_w-1:0] b;
        random_sig(kind == 2, a);
        random_sig(kind == 2, b);
        run_op(a, b, kind != 0, kind != 2, spur);
    endtask

    task automatic end_test(input string name, input int ops, input int base);
        tests++;
        $display("%-18s %0d operations, %0d errors", name, ops, errors - base);
    endtask

    initial begin
        logic [sig_w-1:0] a;
        logic [63:0]      r;
        int               base;
        int               kind;
        int               lat;
        start = 1'b0;
        fa = '0;
        fb = '0;
        fdiv = 1'b0;
        db = 1'b0;
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #drive_delay;
        reset = 1'b0;

        base = errors;
        @(negedge clk);
        checks += 3;
        if (busy !== 1'b0) report_mismatch("busy", busy, 0);
        if (done !== 1'b0) report_mismatch("done", done, 0);
        if (fq !== '0) report_mismatch("fq", fq, 0);
        @(posedge clk);
        #drive_delay;
        end_test("reset state", 0, base);

        base = errors;
        run_op({sig_w{1'b1}}, {sig_w{1'b1}}, 1'b0, 1'b1, 0);
        run_op(sig_w'(1) << 52, sig_w'(1) << 52, 1'b0, 1'b1, 0);
        for (int i = 2; i < n_mul; i++) run_random(0, 0);
        end_test("multiply", n_mul, base);

        // Equal operands give a quotient of exactly one.
        base = errors;
        run_op(sig_w'(1) << 52, sig_w'(1) << 52, 1'b1, 1'b1, 0);
        random_sig(1'b0, a);
        run_op(a, a, 1'b1, 1'b1, 0);
        for (int i = 2; i < n_dp; i++) run_random(1, 0);
        end_test("double divide", n_dp, base);

        base = errors;
        random_sig(1'b1, a);
        run_op(a, a, 1'b1, 1'b0, 0);
        for (int i = 1; i < n_sp; i++) run_random(2, 0);
        end_test("single divide", n_sp, base);

        base = errors;
        for (int i = 0; i < n_busy; i++) begin
            draw_bits(2, r);
            kind = (r[1:0] == 2'd3) ? 0 : int'(r[1:0]);
            lat = (kind == 0) ? mul_latency : (kind == 1) ? div_latency_dp : div_latency_sp;
            draw_bits(4, r);
            run_random(kind, 1 + int'(r[3:0]) % lat);
        end
        end_test("start while busy", n_busy, base);

        base = errors;
        for (int i = 0; i < n_mix; i++) begin
            draw_bits(2, r);
            kind = (r[1:0] == 2'd3) ? 0 : int'(r[1:0]);
            run_random(kind, 0);
        end
        end_test("mixed sequence", n_mix, base);

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles", watchdog_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
verilog/sig_md_pkg.sv
verilog/recip_rom.sv
verilog/nr_datapath.sv
verilog/quot_select.sv
verilog/sig_md_ctrl.sv
verilog/sig_md_top.sv
verification/tb_clock_gen.sv
verification/sig_md_tb.sv
